//--- src/divrem4_defines.svh
`ifndef DIVREM4_DEFINES_SVH
`define DIVREM4_DEFINES_SVH

// --------------------
// Divider sizing
// --------------------

// Operand width of both dividend and divisor
`define DIVREM4_NBITS 32

// Two quotient bits are resolved per iteration
`define DIVREM4_ITERS (`DIVREM4_NBITS / 2)

// State counter width
// Must hold ITERS+1 (idle and done share the low codes)
`define DIVREM4_STATE_BITS 5

`endif

//--- src/divrem4_pkg.sv
`default_nettype none

package divrem4_pkg;

  `include "divrem4_defines.svh"

  // --------------------
  // Handshake payloads
  // --------------------

  // Request word with divisor in the upper half
  typedef struct packed {
    logic [`DIVREM4_NBITS-1:0] divisor;
    logic [`DIVREM4_NBITS-1:0] dividend;
  } div_req_t;

  // Response word with quotient in the upper half
  typedef struct packed {
    logic [`DIVREM4_NBITS-1:0] quotient;
    logic [`DIVREM4_NBITS-1:0] remainder;
  } div_resp_t;

  // --------------------
  // Controller to datapath
  // --------------------

  // Exactly one field is set in any state
  typedef struct packed {
    // Capture operands from the request word
    logic load;
    // Apply one radix-4 step
    logic iterate;
    // Freeze every register while the response waits
    logic hold;
  } dpath_ctrl_t;

endpackage

`default_nettype wire

//--- src/divrem4_step.sv
`timescale 1ns/100ps
`default_nettype none

`include "divrem4_defines.svh"

module divrem4_step (
  input  wire logic [2*`DIVREM4_NBITS-1:0] remainder,
  input  wire logic [2*`DIVREM4_NBITS-1:0] divisor,
  output logic      [2*`DIVREM4_NBITS-1:0] remainder_next,
  output logic      [2*`DIVREM4_NBITS-1:0] divisor_next,
  output logic      [1:0]                  digit
);

  // Divisor pre-shifted for the lower quotient bit
  logic [2*`DIVREM4_NBITS-1:0] divisor_half;

  // First trial against the full divisor
  logic [2*`DIVREM4_NBITS-1:0] diff_hi;
  logic                        nonneg_hi;

  // Remainder left over after the first trial
  logic [2*`DIVREM4_NBITS-1:0] partial;

  // Second trial against half the divisor
  logic [2*`DIVREM4_NBITS-1:0] diff_lo;
  logic                        nonneg_lo;

  // --------------------
  // Upper quotient bit
  // --------------------

  assign diff_hi   = remainder - divisor;

  // Top bit of the difference is its sign
  assign nonneg_hi = ~diff_hi[2*`DIVREM4_NBITS-1];

  // Keep the difference only if the subtraction fit
  assign partial   = nonneg_hi ? diff_hi : remainder;

  // --------------------
  // Lower quotient bit
  // --------------------

  assign divisor_half = divisor >> 1;

  assign diff_lo   = partial - divisor_half;
  assign nonneg_lo = ~diff_lo[2*`DIVREM4_NBITS-1];

  // --------------------
  // Step results
  // --------------------

  // Fall back to the partial remainder when the second trial underflows
  assign remainder_next = nonneg_lo ? diff_lo : partial;

  // A successful trial contributes a one to the quotient
  assign digit = {nonneg_hi, nonneg_lo};

  // Two bits consumed so the divisor moves down by two
  assign divisor_next = divisor >> 2;

endmodule

`default_nettype wire

//--- src/divrem4_dpath.sv
`timescale 1ns/100ps
`default_nettype none

`include "divrem4_defines.svh"

module divrem4_dpath (
  input  wire logic                    clk,
  input  wire divrem4_pkg::div_req_t   req_msg,
  input  wire divrem4_pkg::dpath_ctrl_t ctrl,
  output divrem4_pkg::div_resp_t       resp_msg
);

  // --------------------
  // Registers
  // --------------------

  // Remainder is double width so the trial differences keep a sign bit
  logic [2*`DIVREM4_NBITS-1:0] remainder_q;
  logic [2*`DIVREM4_NBITS-1:0] divisor_q;
  logic [`DIVREM4_NBITS-1:0]   quotient_q;

  // Next values chosen by the control word
  logic [2*`DIVREM4_NBITS-1:0] remainder_d;
  logic [2*`DIVREM4_NBITS-1:0] divisor_d;
  logic [`DIVREM4_NBITS-1:0]   quotient_d;

  // Operands as they enter the register file
  logic [2*`DIVREM4_NBITS-1:0] remainder_init;
  logic [2*`DIVREM4_NBITS-1:0] divisor_init;

  // Outputs of one radix-4 step
  logic [2*`DIVREM4_NBITS-1:0] remainder_step;
  logic [2*`DIVREM4_NBITS-1:0] divisor_step;
  logic [1:0]                  digit;

  // Quotient with the new digit appended
  logic [`DIVREM4_NBITS-1:0]   quotient_step;

  // --------------------
  // Iteration
  // --------------------

  divrem4_step u_step (
    .remainder      (remainder_q),
    .divisor        (divisor_q),
    .remainder_next (remainder_step),
    .divisor_next   (divisor_step),
    .digit          (digit)
  );

  assign quotient_step = (quotient_q << 2) + {{(`DIVREM4_NBITS-2){1'b0}}, digit};

  // --------------------
  // Operand load
  // --------------------

  // Dividend zero-extended into the double-width remainder
  assign remainder_init = {{`DIVREM4_NBITS{1'b0}}, req_msg.dividend};

  // Divisor sits just below the top bit so the first trial
  // weighs the top quotient bit
  assign divisor_init = {1'b0, req_msg.divisor, {(`DIVREM4_NBITS-1){1'b0}}};

  // --------------------
  // Next state select
  // --------------------

  always_comb begin
    remainder_d = remainder_q;
    divisor_d   = divisor_q;
    quotient_d  = quotient_q;
    if (ctrl.load) begin
      remainder_d = remainder_init;
      divisor_d   = divisor_init;
      quotient_d  = '0;
    end else if (ctrl.iterate) begin
      remainder_d = remainder_step;
      divisor_d   = divisor_step;
      quotient_d  = quotient_step;
    end
  end

  // Held registers keep the response word stable under back-pressure
  always_ff @(posedge clk) begin
    if (!ctrl.hold) begin
      remainder_q <= remainder_d;
      divisor_q   <= divisor_d;
      quotient_q  <= quotient_d;
    end
  end

  // --------------------
  // Response
  // --------------------

  // Final remainder always fits in the low half
  always_comb begin
    resp_msg.quotient  = quotient_q;
    resp_msg.remainder = remainder_q[`DIVREM4_NBITS-1:0];
  end

endmodule

`default_nettype wire

//--- src/divrem4_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "divrem4_defines.svh"

module divrem4_ctrl (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire logic             req_val,
  input  wire logic             resp_rdy,
  output logic                  req_rdy,
  output logic                  resp_val,
  output divrem4_pkg::dpath_ctrl_t ctrl
);

  // --------------------
  // State encoding
  // --------------------

  // Idle and done take the two lowest codes
  localparam logic [`DIVREM4_STATE_BITS-1:0] state_idle = `DIVREM4_STATE_BITS'(0);
  localparam logic [`DIVREM4_STATE_BITS-1:0] state_done = `DIVREM4_STATE_BITS'(1);

  // Calculation counts down from here and lands on done
  localparam logic [`DIVREM4_STATE_BITS-1:0] state_calc =
    `DIVREM4_STATE_BITS'(`DIVREM4_ITERS + 1);

  logic [`DIVREM4_STATE_BITS-1:0] state;
  logic [`DIVREM4_STATE_BITS-1:0] state_next;

  logic is_idle;
  logic is_done;
  logic req_go;
  logic resp_go;

  assign is_idle = (state == state_idle);
  assign is_done = (state == state_done);

  // Handshake completions
  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  // --------------------
  // State counter
  // --------------------

  always_comb begin
    state_next = state;
    if (is_idle) begin
      if (req_go) begin
        state_next = state_calc;
      end
    end else if (is_done) begin
      if (resp_go) begin
        state_next = state_idle;
      end
    end else begin
      // One radix-4 step per cycle
      state_next = state - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= state_idle;
    end else begin
      state <= state_next;
    end
  end

  // --------------------
  // Output decode
  // --------------------

  assign req_rdy  = is_idle;
  assign resp_val = is_done;

  // Idle keeps reloading so the accepting edge captures the request
  always_comb begin
    ctrl.load    = is_idle;
    ctrl.iterate = !is_idle && !is_done;
    ctrl.hold    = is_done;
  end

endmodule

`default_nettype wire

//--- src/divrem4.sv
`timescale 1ns/100ps
`default_nettype none

module divrem4 (
  input  wire logic                  clk,
  input  wire logic                  rst,

  // Request side
  input  wire logic                  req_val,
  input  wire divrem4_pkg::div_req_t req_msg,
  output logic                       req_rdy,

  // Response side
  output logic                       resp_val,
  output divrem4_pkg::div_resp_t     resp_msg,
  input  wire logic                  resp_rdy
);

  import divrem4_pkg::*;

  // Register controls decoded from the state counter
  dpath_ctrl_t ctrl;

  // --------------------
  // Controller
  // --------------------

  divrem4_ctrl u_ctrl (
    .clk      (clk),
    .rst      (rst),
    .req_val  (req_val),
    .resp_rdy (resp_rdy),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .ctrl     (ctrl)
  );

  // --------------------
  // Datapath
  // --------------------

  divrem4_dpath u_dpath (
    .clk      (clk),
    .req_msg  (req_msg),
    .ctrl     (ctrl),
    .resp_msg (resp_msg)
  );

endmodule

`default_nettype wire

//--- test/divrem4_assert.sv
`timescale 1ns/100ps
`default_nettype none

module divrem4_assert (
  input wire logic                   clk,
  input wire logic                   rst,
  input wire logic                   req_rdy,
  input wire logic                   resp_val,
  input wire logic                   resp_rdy,
  input wire divrem4_pkg::div_resp_t resp_msg
);

  // Number of property failures so far
  int unsigned failure_count = 0;

  // --------------------
  // Handshake properties
  // --------------------

  // Idle and done are separate states
  property ready_excludes_valid;
    @(posedge clk) disable iff (rst)
      !(req_rdy && resp_val);
  endproperty

  // Response waits unchanged under back-pressure
  property response_held;
    @(posedge clk) disable iff (rst)
      (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_msg));
  endproperty

  // One response per division
  property valid_drops_after_handshake;
    @(posedge clk) disable iff (rst)
      (resp_val && resp_rdy) |=> !resp_val;
  endproperty

  ready_excludes_valid_check: assert property (ready_excludes_valid)
    else begin
      $error("req_rdy and resp_val are high together");
      failure_count++;
    end

  response_held_check: assert property (response_held)
    else begin
      $error("response changed or dropped while resp_rdy was low");
      failure_count++;
    end

  valid_drops_check: assert property (valid_drops_after_handshake)
    else begin
      $error("resp_val stayed high after the completing handshake");
      failure_count++;
    end

endmodule

`default_nettype wire

//--- test/divrem4_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "divrem4_defines.svh"

module divrem4_tb;

  import divrem4_pkg::*;

  localparam int unsigned nbits        = `DIVREM4_NBITS;
  localparam int unsigned latency      = `DIVREM4_ITERS;
  localparam int unsigned clk_period   = 10;
  localparam int unsigned reset_cycles = 16;
  localparam logic [31:0] lfsr_seed    = 32'h92ef_752a;

  // Test sizes
  localparam int unsigned num_directed = 13;
  localparam int unsigned num_random   = 64;
  localparam int unsigned max_stall    = 16;

  // Cycle budget for every division plus slack
  localparam int unsigned budget_cycles = reset_cycles + 100 +
    (num_directed + num_random) * (latency + 4 + max_stall);
  localparam int unsigned timeout_ns = budget_cycles * clk_period;

  logic      clk = 1'b0;
  logic      rst;
  logic      req_val;
  div_req_t  req_msg;
  logic      req_rdy;
  logic      resp_val;
  div_resp_t resp_msg;
  logic      resp_rdy;

  logic [31:0] lfsr_state;
  int unsigned error_count;
  int unsigned check_count;

  always #(clk_period / 2) clk = ~clk;

  divrem4 u_divrem4 (
    .clk      (clk),
    .rst      (rst),
    .req_val  (req_val),
    .req_msg  (req_msg),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_msg (resp_msg),
    .resp_rdy (resp_rdy)
  );

  bind divrem4 divrem4_assert u_assert (
    .clk      (clk),
    .rst      (rst),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp_msg (resp_msg)
  );

  // --------------------
  // Helpers
  // --------------------

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  task automatic take_bits(input int unsigned count, output logic [31:0] value);
    int unsigned i;
    value = '0;
    for (i = 0; i < count; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
  endtask

  // Zero divisor leaves every trial non-negative
  function automatic div_resp_t reference_result(input logic [nbits-1:0] dividend,
                                                 input logic [nbits-1:0] divisor);
    div_resp_t result;
    if (divisor == '0) begin
      result.quotient  = '1;
      result.remainder = dividend;
    end else begin
      result.quotient  = dividend / divisor;
      result.remainder = dividend % divisor;
    end
    return result;
  endfunction

  task automatic compare_response(input div_resp_t got, input div_resp_t expected,
                                  input logic [nbits-1:0] dividend,
                                  input logic [nbits-1:0] divisor);
    check_count++;
    if (got.quotient !== expected.quotient) begin
      $display("FAIL at %0t: %h / %h gave quotient %h, expected %h", $time,
               dividend, divisor, got.quotient, expected.quotient);
      error_count++;
    end
    if (got.remainder !== expected.remainder) begin
      $display("FAIL at %0t: %h / %h gave remainder %h, expected %h", $time,
               dividend, divisor, got.remainder, expected.remainder);
      error_count++;
    end
  endtask

  // Called and returns on a falling edge
  task automatic run_division(input logic [nbits-1:0] dividend,
                              input logic [nbits-1:0] divisor,
                              input int unsigned stall);
    div_resp_t   expected;
    div_resp_t   held;
    int unsigned edges;
    int unsigned i;
    expected = reference_result(dividend, divisor);
    req_msg.divisor  = divisor;
    req_msg.dividend = dividend;
    req_val  = 1'b1;
    resp_rdy = (stall == 0);
    while (!req_rdy) begin
      @(negedge clk);
    end
    // Accepting edge
    @(negedge clk);
    req_val = 1'b0;
    edges = 0;
    while (!resp_val && edges < 4 * latency) begin
      @(negedge clk);
      edges++;
    end
    if (!resp_val) begin
      $display("No response arrived for %h / %h within %0d cycles",
               dividend, divisor, 4 * latency);
      error_count++;
      return;
    end
    check_count++;
    if (edges != latency) begin
      $display("FAIL at %0t: resp_val rose %0d edges after acceptance, expected %0d",
               $time, edges, latency);
      error_count++;
    end
    held = resp_msg;
    compare_response(held, expected, dividend, divisor);

    // Back-pressure with a competing request on the bus
    for (i = 0; i < stall; i++) begin
      req_msg = ~req_msg;
      req_val = 1'b1;
      @(negedge clk);
      check_count++;
      if (resp_val !== 1'b1 || resp_msg !== held) begin
        $display("FAIL at %0t: response changed under back-pressure, %h now %h",
                 $time, held, resp_msg);
        error_count++;
      end
      if (req_rdy !== 1'b0) begin
        $display("FAIL at %0t: req_rdy rose while a response was pending", $time);
        error_count++;
      end
    end
    req_val  = 1'b0;
    resp_rdy = 1'b1;

    // Completing edge
    @(negedge clk);
    check_count++;
    if (resp_val !== 1'b0 || req_rdy !== 1'b1) begin
      $display("FAIL at %0t: after completion resp_val=%b req_rdy=%b, expected 0 and 1",
               $time, resp_val, req_rdy);
      error_count++;
    end
  endtask

  // --------------------
  // Tests
  // --------------------

  task automatic test_reset_state;
    check_count++;
    if (req_rdy !== 1'b1 || resp_val !== 1'b0) begin
      $display("FAIL at %0t: after reset req_rdy=%b resp_val=%b, expected 1 and 0",
               $time, req_rdy, resp_val);
      error_count++;
    end
  endtask

  task automatic test_fixed_cases;
    run_division(32'd100, 32'd7, 0);
    run_division(32'd37, 32'd1000, 0);
    run_division(32'hdead_beef, 32'd1, 0);
    run_division(32'hffff_ffff, 32'd10, 0);
    run_division(32'hffff_ffff, 32'h8000_0001, 0);
    run_division(32'h1234_5678, 32'h1234_5678, 0);
    run_division(32'hffff_ffff, 32'hffff_ffff, 0);
  endtask

  task automatic test_zero_divisor;
    run_division(32'hcafe_f00d, 32'd0, 0);
    run_division(32'd0, 32'd0, 0);
  endtask

  task automatic test_backpressure;
    logic [31:0] dividend;
    logic [31:0] divisor;
    logic [31:0] stall;
    int unsigned n;
    for (n = 0; n < 4; n++) begin
      take_bits(32, dividend);
      take_bits(16, divisor);
      take_bits(4, stall);
      run_division(dividend, divisor, stall + 1);
    end
  endtask

  task automatic test_random;
    logic [31:0] dividend;
    logic [31:0] divisor;
    int unsigned n;
    for (n = 0; n < num_random; n++) begin
      take_bits(32, dividend);
      take_bits(32, divisor);
      // Narrow some divisors so quotients are not mostly zero
      if (n % 2 == 1) begin
        divisor = divisor >> (n % 31);
      end
      run_division(dividend, divisor, 0);
    end
  endtask

  // --------------------
  // Sequence
  // --------------------

  initial begin
    #(timeout_ns);
    $display("Watchdog expired after %0d ns with tests still running", timeout_ns);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    rst         = 1'b1;
    req_val     = 1'b0;
    req_msg     = '0;
    resp_rdy    = 1'b0;
    lfsr_state  = lfsr_seed;
    error_count = 0;
    check_count = 0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    test_reset_state();
    test_fixed_cases();
    test_zero_divisor();
    test_backpressure();
    test_random();

    // Handshake properties that fired during the run
    error_count += u_divrem4.u_assert.failure_count;

    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+src
src/divrem4_pkg.sv
src/divrem4_step.sv
src/divrem4_dpath.sv
src/divrem4_ctrl.sv
src/divrem4.sv
test/divrem4_assert.sv
test/divrem4_tb.sv
